// ==== Bender.yml ====
package:
  name: rv_reg_stage

sources:
  - rv_regs_pkg.sv
  - rv_src_decode.sv
  - rv_dbg_access.sv
  - rv_regfile.sv
  - rv_opnd_bypass.sv
  - rv_reg_stage.sv
  - target: test
    files:
      - rv_reg_stage_tb.sv

// ==== flist.f ====
rv_regs_pkg.sv
rv_src_decode.sv
rv_dbg_access.sv
rv_regfile.sv
rv_opnd_bypass.sv
rv_reg_stage.sv
rv_reg_stage_tb.sv

// ==== rv_dbg_access.sv ====
module rv_dbg_access (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  rv_regs_pkg::dbg_req_t             dbg_req_i,
  input  logic [rv_regs_pkg::XLEN-1:0]      rf_dat_i,
  output rv_regs_pkg::rf_dbg_cmd_t          rf_cmd_o,
  output rv_regs_pkg::dbg_rsp_t             dbg_rsp_o
);

  // Response tracking, one entry per stage
  typedef struct packed {
    logic valid;
    logic err;
    logic rd;
  } rsp_stage_t;

  logic       in_win;
  rsp_stage_t s1_q;
  rsp_stage_t s2_q;
  logic       wr_rsp;
  logic       rd_rsp;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  // Upper bits select the 32-entry GPR window
  assign in_win = dbg_req_i.addr[rv_regs_pkg::DBG_AW-1:rv_regs_pkg::REG_AW] ==
                  rv_regs_pkg::DBG_GPR_BASE[rv_regs_pkg::DBG_AW-1:rv_regs_pkg::REG_AW];

  // Commands only for addresses inside the window
  assign rf_cmd_o.re   = dbg_req_i.valid & ~dbg_req_i.we & in_win;
  assign rf_cmd_o.we   = dbg_req_i.valid &  dbg_req_i.we & in_win;
  assign rf_cmd_o.idx  = dbg_req_i.addr[rv_regs_pkg::REG_AW-1:0];
  assign rf_cmd_o.data = dbg_req_i.data;

  ////////////////////////////////////////////////////////////////////////////
  // Response pipeline
  ////////////////////////////////////////////////////////////////////////////

  // Stage 1 lines up with the borrowed read address
  // Stage 2 lines up with the registered read data
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      s1_q <= '0;
      s2_q <= '0;
    end
    else
    begin
      s1_q.valid <= dbg_req_i.valid;
      s1_q.err   <= ~in_win;
      s1_q.rd    <= ~dbg_req_i.we;
      s2_q       <= s1_q;
    end
  end

  // Writes answer after one stage, reads after two
  assign wr_rsp = s1_q.valid & ~s1_q.rd;
  assign rd_rsp = s2_q.valid &  s2_q.rd;

  assign dbg_rsp_o.valid = wr_rsp | rd_rsp;
  assign dbg_rsp_o.err   = wr_rsp ? s1_q.err : (rd_rsp & s2_q.err);
  // No data on writes or rejected reads
  assign dbg_rsp_o.data  = (rd_rsp & ~s2_q.err) ? rf_dat_i : '0;

  // One read in flight at a time
  a_no_req_in_read : assert property (
    @(posedge clk_i) disable iff (rst_i) (s1_q.valid && s1_q.rd) |-> !dbg_req_i.valid
  );

endmodule

// ==== rv_opnd_bypass.sv ====
module rv_opnd_bypass (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              stall_i,
  input  rv_regs_pkg::src_req_t             rd_src_i,
  input  logic [rv_regs_pkg::XLEN-1:0]      rs1_data_i,
  input  logic [rv_regs_pkg::XLEN-1:0]      rs2_data_i,
  input  rv_regs_pkg::wb_req_t              wb_i,
  output rv_regs_pkg::operand_t             opnd_o
);

  // Forward hits, x0 never matches
  logic                         hit1;
  logic                         hit2;
  logic [rv_regs_pkg::XLEN-1:0] rs1_fwd;
  logic [rv_regs_pkg::XLEN-1:0] rs2_fwd;

  // Output register
  logic                         valid_q;
  rv_regs_pkg::reg_idx_t        rd_q;
  logic [rv_regs_pkg::XLEN-1:0] rs1_q;
  logic [rv_regs_pkg::XLEN-1:0] rs2_q;

  ////////////////////////////////////////////////////////////////////////////
  // Same-cycle forwarding
  ////////////////////////////////////////////////////////////////////////////

  assign hit1 = wb_i.we && (wb_i.rd != '0) && (wb_i.rd == rd_src_i.rs1);
  assign hit2 = wb_i.we && (wb_i.rd != '0) && (wb_i.rd == rd_src_i.rs2);

  assign rs1_fwd = hit1 ? wb_i.data : rs1_data_i;
  assign rs2_fwd = hit2 ? wb_i.data : rs2_data_i;

  // Valid under reset, payload follows it
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      valid_q <= 1'b0;
    end
    else if (!stall_i)
    begin
      valid_q <= rd_src_i.valid;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      rd_q  <= rd_src_i.rd;
      rs1_q <= rs1_fwd;
      rs2_q <= rs2_fwd;
    end
  end

  assign opnd_o.valid   = valid_q;
  assign opnd_o.rd      = rd_q;
  assign opnd_o.rs1_val = rs1_q;
  assign opnd_o.rs2_val = rs2_q;

  // Source x0 reaches execute as zero, register file read included
  a_rs1_x0_zero : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (!stall_i && rd_src_i.valid && rd_src_i.rs1 == '0) |=> (opnd_o.rs1_val == '0)
  );

  a_rs2_x0_zero : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (!stall_i && rd_src_i.valid && rd_src_i.rs2 == '0) |=> (opnd_o.rs2_val == '0)
  );

endmodule

// ==== rv_reg_stage.sv ====
module rv_reg_stage (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    stall_i,
  // Issue and writeback
  input  rv_regs_pkg::issue_req_t issue_i,
  input  rv_regs_pkg::wb_req_t    wb_i,
  // Debug unit
  input  rv_regs_pkg::dbg_req_t   dbg_req_i,
  // To execute
  output rv_regs_pkg::operand_t   opnd_o,
  output rv_regs_pkg::dbg_rsp_t   dbg_rsp_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////////////////////////////////////////

  // Decoded register numbers
  rv_regs_pkg::src_req_t        src;
  // Held numbers and raw read data
  rv_regs_pkg::src_req_t        rd_src;
  logic [rv_regs_pkg::XLEN-1:0] rs1_data;
  logic [rv_regs_pkg::XLEN-1:0] rs2_data;
  // Debug path
  rv_regs_pkg::rf_dbg_cmd_t     dbg_cmd;
  logic [rv_regs_pkg::XLEN-1:0] dbg_data;

  // Input side, instruction fields
  rv_src_decode i_rv_src_decode (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .stall_i (stall_i),
    .issue_i (issue_i),
    .src_o   (src)
  );

  // Input side, debug address window
  rv_dbg_access i_rv_dbg_access (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .dbg_req_i (dbg_req_i),
    .rf_dat_i  (dbg_data),
    .rf_cmd_o  (dbg_cmd),
    .dbg_rsp_o (dbg_rsp_o)
  );

  // Register file
  rv_regfile i_rv_regfile (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .stall_i    (stall_i),
    .src_i      (src),
    .wb_i       (wb_i),
    .dbg_cmd_i  (dbg_cmd),
    .rd_src_o   (rd_src),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .dbg_data_o (dbg_data)
  );

  // Output side, forwarding and operand register
  rv_opnd_bypass i_rv_opnd_bypass (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .stall_i    (stall_i),
    .rd_src_i   (rd_src),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .wb_i       (wb_i),
    .opnd_o     (opnd_o)
  );

endmodule

// ==== rv_reg_stage_tb.sv ====
module rv_reg_stage_tb;

  // Cycles allowed for any awaited strobe
  localparam int TIMEOUT = 20;

  logic                     clk_i;
  logic                     rst_i;
  logic                     stall_i;
  rv_regs_pkg::issue_req_t  issue_i;
  rv_regs_pkg::wb_req_t     wb_i;
  rv_regs_pkg::dbg_req_t    dbg_req_i;
  rv_regs_pkg::operand_t    opnd_o;
  rv_regs_pkg::dbg_rsp_t    dbg_rsp_o;

  // Reference register contents, x0 stays zero
  logic [31:0] model [32];
  integer      seed;
  int          errors;
  int          checks;
  bit          timed_out;

  rv_reg_stage i_rv_reg_stage (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .stall_i   (stall_i),
    .issue_i   (issue_i),
    .wb_i      (wb_i),
    .dbg_req_i (dbg_req_i),
    .opnd_o    (opnd_o),
    .dbg_rsp_o (dbg_rsp_o)
  );

  always #50 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_values(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timed_out = 1'b1;
    errors++;
    $display("Timeout at %0t: %s did not rise within %0d cycles", $time, what, TIMEOUT);
  endtask

  task automatic end_of_test(input string name, input int err_start);
    $display("Test %s finished with %0d errors", name, errors - err_start);
  endtask

  // Junk in funct7 and funct3 on every format
  function automatic logic [31:0] make_instr(input logic [6:0] opc,
                                             input rv_regs_pkg::reg_idx_t rs1,
                                             input rv_regs_pkg::reg_idx_t rs2,
                                             input rv_regs_pkg::reg_idx_t rd);
    return {7'h5a, rs2, rs1, 3'b101, rd, opc};
  endfunction

  // Nonzero so that unused sources are told apart from used ones
  function automatic logic [31:0] rand_data();
    logic [31:0] v;
    v = $random(seed);
    if (v == 32'h0)
    begin
      v = 32'h1;
    end
    return v;
  endfunction

  task automatic set_stall(input logic v);
    @(negedge clk_i);
    stall_i = v;
  endtask

  // One writeback strobe, model follows the x0 rule
  task automatic write_back(input rv_regs_pkg::reg_idx_t idx, input logic [31:0] data);
    @(negedge clk_i);
    wb_i.we   = 1'b1;
    wb_i.rd   = idx;
    wb_i.data = data;
    @(negedge clk_i);
    wb_i.we = 1'b0;
    if (idx != 5'd0)
    begin
      model[idx] = data;
    end
  endtask

  // Issue one instruction, optional writeback in the following cycle
  task automatic issue_and_check(input logic [31:0] instr,
                                 input rv_regs_pkg::reg_idx_t exp_rd,
                                 input logic [31:0] exp1, input logic [31:0] exp2,
                                 input logic fwd_we, input rv_regs_pkg::reg_idx_t fwd_rd,
                                 input logic [31:0] fwd_data);
    int n;
    n = 0;
    @(negedge clk_i);
    issue_i.valid = 1'b1;
    issue_i.instr = instr;
    @(negedge clk_i);
    issue_i.valid = 1'b0;
    wb_i.we       = fwd_we;
    wb_i.rd       = fwd_rd;
    wb_i.data     = fwd_data;
    @(negedge clk_i);
    wb_i.we = 1'b0;
    if (fwd_we && (fwd_rd != 5'd0))
    begin
      model[fwd_rd] = fwd_data;
    end
    while (!opnd_o.valid && (n < TIMEOUT))
    begin
      @(negedge clk_i);
      n++;
    end
    if (!opnd_o.valid)
    begin
      report_timeout("opnd_o.valid");
    end
    else
    begin
      compare_values("opnd_o.rd", 32'(opnd_o.rd), 32'(exp_rd));
      compare_values("opnd_o.rs1_val", opnd_o.rs1_val, exp1);
      compare_values("opnd_o.rs2_val", opnd_o.rs2_val, exp2);
    end
  endtask

  // Debug request with a writeback alongside it, waits for the response
  task automatic debug_xfer(input logic we, input logic [11:0] addr, input logic [31:0] data,
                            input rv_regs_pkg::wb_req_t wb_side,
                            output logic err, output logic [31:0] rdata);
    int n;
    n     = 0;
    err   = 1'b0;
    rdata = 32'h0;
    @(negedge clk_i);
    dbg_req_i.valid = 1'b1;
    dbg_req_i.we    = we;
    dbg_req_i.addr  = addr;
    dbg_req_i.data  = data;
    wb_i            = wb_side;
    @(negedge clk_i);
    dbg_req_i.valid = 1'b0;
    wb_i.we         = 1'b0;
    while (!dbg_rsp_o.valid && (n < TIMEOUT))
    begin
      @(negedge clk_i);
      n++;
    end
    if (!dbg_rsp_o.valid)
    begin
      report_timeout("dbg_rsp_o.valid");
    end
    else
    begin
      err   = dbg_rsp_o.err;
      rdata = dbg_rsp_o.data;
    end
  endtask

  // Debug read borrows rs1, so the pipeline is held around it
  task automatic debug_read_check(input logic [11:0] addr, input logic exp_err,
                                  input logic [31:0] exp_data);
    rv_regs_pkg::wb_req_t no_wb;
    logic                 err;
    logic [31:0]          rdata;
    no_wb = '0;
    set_stall(1'b1);
    debug_xfer(1'b0, addr, 32'h0, no_wb, err, rdata);
    set_stall(1'b0);
    compare_values("dbg_rsp_o.err", 32'(err), 32'(exp_err));
    compare_values("dbg_rsp_o.data", rdata, exp_data);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic writeback_then_read();
    int start;
    start = errors;
    for (int i = 1; i < 32; i++)
    begin
      write_back(5'(i), rand_data());
    end
    // All source pairs, x0 included
    for (int a = 0; (a < 32) && !timed_out; a++)
    begin
      for (int b = 0; (b < 32) && !timed_out; b++)
      begin
        issue_and_check(make_instr(rv_regs_pkg::OPC_OP, 5'(a), 5'(b), 5'(a + b)),
                        5'(a + b), model[a], model[b], 1'b0, 5'd0, 32'h0);
      end
    end
    end_of_test("writeback_then_read", start);
  endtask

  task automatic x0_handling();
    int start;
    start = errors;
    write_back(5'd0, 32'hdeadbeef);
    issue_and_check(make_instr(rv_regs_pkg::OPC_OP, 5'd0, 5'd0, 5'd3),
                    5'd3, 32'h0, 32'h0, 1'b0, 5'd0, 32'h0);
    issue_and_check(make_instr(rv_regs_pkg::OPC_OP, 5'd0, 5'd5, 5'd6),
                    5'd6, 32'h0, model[5], 1'b0, 5'd0, 32'h0);
    issue_and_check(make_instr(rv_regs_pkg::OPC_OP, 5'd5, 5'd0, 5'd7),
                    5'd7, model[5], 32'h0, 1'b0, 5'd0, 32'h0);
    end_of_test("x0_handling", start);
  endtask

  task automatic forwarding();
    int          start;
    logic [31:0] v;
    start = errors;
    v = rand_data();
    issue_and_check(make_instr(rv_regs_pkg::OPC_OP, 5'd4, 5'd9, 5'd1),
                    5'd1, v, model[9], 1'b1, 5'd4, v);
    v = rand_data();
    issue_and_check(make_instr(rv_regs_pkg::OPC_OP, 5'd4, 5'd9, 5'd2),
                    5'd2, model[4], v, 1'b1, 5'd9, v);
    // Same register on both sources
    v = rand_data();
    issue_and_check(make_instr(rv_regs_pkg::OPC_OP, 5'd4, 5'd4, 5'd5),
                    5'd5, v, v, 1'b1, 5'd4, v);
    // Unrelated destination, no forward
    v = rand_data();
    issue_and_check(make_instr(rv_regs_pkg::OPC_OP, 5'd4, 5'd9, 5'd3),
                    5'd3, model[4], model[9], 1'b1, 5'd17, v);
    // x0 destination never matches
    issue_and_check(make_instr(rv_regs_pkg::OPC_OP, 5'd0, 5'd9, 5'd8),
                    5'd8, 32'h0, model[9], 1'b1, 5'd0, rand_data());
    end_of_test("forwarding", start);
  endtask

  task automatic format_decode();
    int start;
    start = errors;
    // Fields name x7, x9 and x12 on every format
    issue_and_check(make_instr(rv_regs_pkg::OPC_LUI, 5'd7, 5'd9, 5'd12),
                    5'd12, 32'h0, 32'h0, 1'b0, 5'd0, 32'h0);
    issue_and_check(make_instr(rv_regs_pkg::OPC_AUIPC, 5'd7, 5'd9, 5'd12),
                    5'd12, 32'h0, 32'h0, 1'b0, 5'd0, 32'h0);
    issue_and_check(make_instr(rv_regs_pkg::OPC_JAL, 5'd7, 5'd9, 5'd12),
                    5'd12, 32'h0, 32'h0, 1'b0, 5'd0, 32'h0);
    issue_and_check(make_instr(rv_regs_pkg::OPC_STORE, 5'd7, 5'd9, 5'd12),
                    5'd0, model[7], model[9], 1'b0, 5'd0, 32'h0);
    issue_and_check(make_instr(rv_regs_pkg::OPC_BRANCH, 5'd7, 5'd9, 5'd12),
                    5'd0, model[7], model[9], 1'b0, 5'd0, 32'h0);
    issue_and_check(make_instr(rv_regs_pkg::OPC_OPIMM, 5'd7, 5'd9, 5'd12),
                    5'd12, model[7], 32'h0, 1'b0, 5'd0, 32'h0);
    issue_and_check(make_instr(rv_regs_pkg::OPC_LOAD, 5'd7, 5'd9, 5'd12),
                    5'd12, model[7], 32'h0, 1'b0, 5'd0, 32'h0);
    issue_and_check(make_instr(rv_regs_pkg::OPC_JALR, 5'd7, 5'd9, 5'd12),
                    5'd12, model[7], 32'h0, 1'b0, 5'd0, 32'h0);
    issue_and_check(make_instr(rv_regs_pkg::OPC_SYSTEM, 5'd7, 5'd9, 5'd12),
                    5'd12, model[7], 32'h0, 1'b0, 5'd0, 32'h0);
    // Unknown opcode gives all numbers x0
    issue_and_check(make_instr(7'b1111111, 5'd7, 5'd9, 5'd12),
                    5'd0, 32'h0, 32'h0, 1'b0, 5'd0, 32'h0);
    end_of_test("format_decode", start);
  endtask

  task automatic stall_hold();
    int          start;
    logic [31:0] v;
    logic [31:0] a1;
    logic [31:0] a2;
    start = errors;
    v     = rand_data();
    a1    = model[2];
    a2    = model[3];
    // A in the output register, B held in the source registers
    @(negedge clk_i);
    issue_i.valid = 1'b1;
    issue_i.instr = make_instr(rv_regs_pkg::OPC_OP, 5'd2, 5'd3, 5'd6);
    @(negedge clk_i);
    issue_i.instr = make_instr(rv_regs_pkg::OPC_OP, 5'd10, 5'd11, 5'd8);
    @(negedge clk_i);
    issue_i.valid = 1'b0;
    stall_i       = 1'b1;
    for (int i = 0; i < 4; i++)
    begin
      compare_values("opnd_o.valid", 32'(opnd_o.valid), 32'h1);
      compare_values("opnd_o.rd", 32'(opnd_o.rd), 32'd6);
      compare_values("opnd_o.rs1_val", opnd_o.rs1_val, a1);
      compare_values("opnd_o.rs2_val", opnd_o.rs2_val, a2);
      // Writeback to B's rs1 while held
      wb_i.we   = (i == 0);
      wb_i.rd   = 5'd10;
      wb_i.data = v;
      @(negedge clk_i);
    end
    model[10] = v;
    stall_i   = 1'b0;
    // Release edge captures B
    @(negedge clk_i);
    compare_values("opnd_o.valid", 32'(opnd_o.valid), 32'h1);
    compare_values("opnd_o.rd", 32'(opnd_o.rd), 32'd8);
    compare_values("opnd_o.rs1_val", opnd_o.rs1_val, v);
    compare_values("opnd_o.rs2_val", opnd_o.rs2_val, model[11]);
    @(negedge clk_i);
    compare_values("opnd_o.valid", 32'(opnd_o.valid), 32'h0);
    end_of_test("stall_hold", start);
  endtask

  task automatic debug_access();
    int                   start;
    rv_regs_pkg::wb_req_t side;
    logic                 err;
    logic [31:0]          rdata;
    logic [31:0]          d1;
    logic [31:0]          d2;
    start = errors;
    side  = '0;
    // Write in the window, read back both ways
    d1 = rand_data();
    debug_xfer(1'b1, rv_regs_pkg::DBG_GPR_BASE + 12'd13, d1, side, err, rdata);
    model[13] = d1;
    compare_values("dbg_rsp_o.err", 32'(err), 32'h0);
    compare_values("dbg_rsp_o.data", rdata, 32'h0);
    debug_read_check(rv_regs_pkg::DBG_GPR_BASE + 12'd13, 1'b0, d1);
    issue_and_check(make_instr(rv_regs_pkg::OPC_OP, 5'd13, 5'd0, 5'd1),
                    5'd1, d1, 32'h0, 1'b0, 5'd0, 32'h0);
    debug_read_check(rv_regs_pkg::DBG_GPR_BASE, 1'b0, 32'h0);
    // Debug write against a writeback to the same register
    d1        = rand_data();
    d2        = rand_data();
    side.we   = 1'b1;
    side.rd   = 5'd14;
    side.data = d2;
    debug_xfer(1'b1, rv_regs_pkg::DBG_GPR_BASE + 12'd14, d1, side, err, rdata);
    model[14] = d1;
    compare_values("dbg_rsp_o.err", 32'(err), 32'h0);
    debug_read_check(rv_regs_pkg::DBG_GPR_BASE + 12'd14, 1'b0, d1);
    issue_and_check(make_instr(rv_regs_pkg::OPC_OP, 5'd14, 5'd13, 5'd2),
                    5'd2, d1, model[13], 1'b0, 5'd0, 32'h0);
    // Outside the window, low bits name x5
    side = '0;
    debug_xfer(1'b1, rv_regs_pkg::DBG_GPR_BASE + 12'h025, rand_data(), side, err, rdata);
    compare_values("dbg_rsp_o.err", 32'(err), 32'h1);
    compare_values("dbg_rsp_o.data", rdata, 32'h0);
    debug_read_check(rv_regs_pkg::DBG_GPR_BASE + 12'h3e5, 1'b1, 32'h0);
    debug_read_check(rv_regs_pkg::DBG_GPR_BASE + 12'd5, 1'b0, model[5]);
    issue_and_check(make_instr(rv_regs_pkg::OPC_OP, 5'd5, 5'd14, 5'd3),
                    5'd3, model[5], model[14], 1'b0, 5'd0, 32'h0);
    end_of_test("debug_access", start);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    clk_i     = 1'b0;
    rst_i     = 1'b1;
    stall_i   = 1'b0;
    issue_i   = '0;
    wb_i      = '0;
    dbg_req_i = '0;
    seed      = 32'ha299;
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    for (int i = 0; i < 32; i++)
    begin
      model[i] = 32'h0;
    end
    repeat (8) @(negedge clk_i);
    rst_i = 1'b0;
    compare_values("opnd_o.valid", 32'(opnd_o.valid), 32'h0);
    compare_values("dbg_rsp_o.valid", 32'(dbg_rsp_o.valid), 32'h0);
    writeback_then_read();
    if (!timed_out)
    begin
      x0_handling();
    end
    if (!timed_out)
    begin
      forwarding();
    end
    if (!timed_out)
    begin
      format_decode();
    end
    if (!timed_out)
    begin
      stall_hold();
    end
    if (!timed_out)
    begin
      debug_access();
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if ((errors == 0) && !timed_out)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== rv_regfile.sv ====
module rv_regfile (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              stall_i,
  input  rv_regs_pkg::src_req_t             src_i,
  input  rv_regs_pkg::wb_req_t              wb_i,
  input  rv_regs_pkg::rf_dbg_cmd_t          dbg_cmd_i,
  output rv_regs_pkg::src_req_t             rd_src_o,
  output logic [rv_regs_pkg::XLEN-1:0]      rs1_data_o,
  output logic [rv_regs_pkg::XLEN-1:0]      rs2_data_o,
  output logic [rv_regs_pkg::XLEN-1:0]      dbg_data_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Storage and read address registers
  ////////////////////////////////////////////////////////////////////////////

  // General registers, x0 entry never written
  logic [rv_regs_pkg::XLEN-1:0] rf_q [rv_regs_pkg::NREGS];

  // Held source numbers
  rv_regs_pkg::src_req_t        src_q;

  // Combinational read data
  logic [rv_regs_pkg::XLEN-1:0] rd1;
  logic [rv_regs_pkg::XLEN-1:0] rd2;

  // Debug read in flight, one cycle behind the address
  logic                         dbg_re_q;
  logic [rv_regs_pkg::XLEN-1:0] dbg_data_q;

  // Addresses hold while stalled
  // Debug read takes over rs1 for one cycle
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      src_q <= '0;
    end
    else
    begin
      if (!stall_i)
      begin
        src_q <= src_i;
      end
      if (dbg_cmd_i.re)
      begin
        src_q.rs1 <= dbg_cmd_i.idx;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////////////////////

  // Asynchronous from the held address, so stall-time writes show up
  // x0 always zero
  assign rd1 = (src_q.rs1 == '0) ? '0 : rf_q[src_q.rs1];
  assign rd2 = (src_q.rs2 == '0) ? '0 : rf_q[src_q.rs2];

  assign rd_src_o   = src_q;
  assign rs1_data_o = rd1;
  assign rs2_data_o = rd2;

  // Debug read data, captured from the borrowed rs1
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      dbg_re_q <= 1'b0;
    end
    else
    begin
      dbg_re_q <= dbg_cmd_i.re;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (dbg_re_q)
    begin
      dbg_data_q <= rd1;
    end
  end

  assign dbg_data_o = dbg_data_q;

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////

  // Debug wins over writeback, x0 writes dropped
  always_ff @(posedge clk_i)
  begin
    if (dbg_cmd_i.we)
    begin
      if (dbg_cmd_i.idx != '0)
      begin
        rf_q[dbg_cmd_i.idx] <= dbg_cmd_i.data;
      end
    end
    else if (wb_i.we && (wb_i.rd != '0))
    begin
      rf_q[wb_i.rd] <= wb_i.data;
    end
  end

  // Debug unit may only borrow rs1 when the pipeline is held
  a_dbg_read_in_stall : assert property (
    @(posedge clk_i) disable iff (rst_i) dbg_cmd_i.re |-> stall_i
  );

endmodule

// ==== rv_regs_pkg.sv ====
package rv_regs_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Integer register width
  localparam int unsigned XLEN   = 32;
  // General registers x0..x31
  localparam int unsigned NREGS  = 32;
  localparam int unsigned REG_AW = $clog2(NREGS);
  // Debug address space
  localparam int unsigned DBG_AW = 12;

  // GPR window base 0x1000, truncated to the 12-bit debug port
  // Window covers base up to base+31
  localparam logic [DBG_AW-1:0] DBG_GPR_BASE = DBG_AW'(32'h1000);

  // Major opcodes, instr[6:0]
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [REG_AW-1:0] reg_idx_t;

  // Issued instruction, one strobe per instruction
  typedef struct packed {
    logic            valid;
    logic [31:0]     instr;
  } issue_req_t;

  // Decoded register numbers, unused ones are zero
  typedef struct packed {
    logic     valid;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
  } src_req_t;

  // Writeback port
  typedef struct packed {
    logic            we;
    reg_idx_t        rd;
    logic [XLEN-1:0] data;
  } wb_req_t;

  // Debug unit request and response
  typedef struct packed {
    logic              valid;
    logic              we;
    logic [DBG_AW-1:0] addr;
    logic [XLEN-1:0]   data;
  } dbg_req_t;

  typedef struct packed {
    logic            valid;
    logic            err;
    logic [XLEN-1:0] data;
  } dbg_rsp_t;

  // Decoded debug command towards the register file
  typedef struct packed {
    logic            re;
    logic            we;
    reg_idx_t        idx;
    logic [XLEN-1:0] data;
  } rf_dbg_cmd_t;

  // Stage output to execute
  typedef struct packed {
    logic            valid;
    reg_idx_t        rd;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
  } operand_t;

endpackage

// ==== rv_src_decode.sv ====
module rv_src_decode (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   stall_i,
  input  rv_regs_pkg::issue_req_t issue_i,
  output rv_regs_pkg::src_req_t   src_o
);

  // Raw instruction fields
  logic [6:0]            opcode;
  rv_regs_pkg::reg_idx_t fld_rs1;
  rv_regs_pkg::reg_idx_t fld_rs2;
  rv_regs_pkg::reg_idx_t fld_rd;

  // Per-format field usage
  logic use_rs1;
  logic use_rs2;
  logic use_rd;

  assign opcode  = issue_i.instr[6:0];
  assign fld_rd  = issue_i.instr[11:7];
  assign fld_rs1 = issue_i.instr[19:15];
  assign fld_rs2 = issue_i.instr[24:20];

  ////////////////////////////////////////////////////////////////////////////
  // Format select
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_rd  = 1'b0;
    case (opcode)
      // U and J formats, destination only
      rv_regs_pkg::OPC_LUI,
      rv_regs_pkg::OPC_AUIPC,
      rv_regs_pkg::OPC_JAL:
      begin
        use_rd = 1'b1;
      end
      // I formats, no rs2
      rv_regs_pkg::OPC_JALR,
      rv_regs_pkg::OPC_LOAD,
      rv_regs_pkg::OPC_OPIMM,
      rv_regs_pkg::OPC_SYSTEM:
      begin
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
      end
      // S and B formats, no destination
      rv_regs_pkg::OPC_STORE,
      rv_regs_pkg::OPC_BRANCH:
      begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      // R format
      rv_regs_pkg::OPC_OP:
      begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        use_rd  = 1'b1;
      end
      // Unknown opcode keeps all numbers at x0
      default:
      begin
        use_rs1 = 1'b0;
      end
    endcase
  end

  // Unused numbers forced to x0
  assign src_o.valid = issue_i.valid;
  assign src_o.rs1   = use_rs1 ? fld_rs1 : '0;
  assign src_o.rs2   = use_rs2 ? fld_rs2 : '0;
  assign src_o.rd    = use_rd  ? fld_rd  : '0;

  // Issue only while the pipeline is running
  a_no_issue_in_stall : assert property (
    @(posedge clk_i) disable iff (rst_i) stall_i |-> !issue_i.valid
  );

endmodule
